/* design/xc_config.svh */
// --------------------
// correlator sizes
// --------------------
`ifndef XC_CONFIG_SVH
`define XC_CONFIG_SVH

// input lines and lags
`define XC_NUM_LINES 4
`define XC_MAX_LAG 2

// one counter word
`define XC_RESOLUTION 16

// 4 pulse + 8 auto + 6 pairs of 5 lags
`define XC_NUM_PAIRS 6
`define XC_NUM_COUNTS 42
`define XC_LEN_WIDTH 16

`endif

/* design/xc_types_pkg.sv */
// --------------------
// correlator types
// --------------------
`default_nettype none
`include "xc_config.svh"

package xc_types_pkg;

	// auto lags per line, cross lags per pair
	localparam int num_auto = `XC_NUM_LINES * `XC_MAX_LAG;
	localparam int cross_span = 2 * `XC_MAX_LAG + 1;

	typedef logic [`XC_RESOLUTION-1:0] count_t;

	typedef struct packed {
		logic [`XC_NUM_LINES-1:0] tap0;
		logic [`XC_NUM_LINES-1:0] tap1;
		logic [`XC_NUM_LINES-1:0] tap2;
	} taps_t;

	// pulse 0..3, auto 4..11, cross 12..41
	typedef count_t [`XC_NUM_COUNTS-1:0] count_vec_t;

	typedef struct packed {
		logic start;
		logic [`XC_LEN_WIDTH-1:0] int_len;
		logic [`XC_NUM_LINES-1:0] invert;
	} xc_ctrl_t;

	typedef struct packed {
		logic busy;
		logic done;
		logic [15:0] checksum;
	} xc_status_t;

	typedef enum logic [2:0] {
		st_idle,
		st_clear,
		st_integrate,
		st_checksum,
		st_done
	} xc_state_e;

endpackage

`default_nettype wire

/* design/xc_axil_pkg.sv */
// --------------------
// AXI4-Lite types
// --------------------
`default_nettype none

package xc_axil_pkg;

	localparam int axil_addr_w = 12;
	localparam int axil_data_w = 32;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	// master side
	typedef struct packed {
		logic awvalid;
		logic [axil_addr_w-1:0] awaddr;
		logic wvalid;
		logic [axil_data_w-1:0] wdata;
		logic [axil_data_w/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [axil_addr_w-1:0] araddr;
		logic rready;
	} axil_req_t;

	// slave side
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axil_resp_e bresp;
		logic arready;
		logic rvalid;
		logic [axil_data_w-1:0] rdata;
		axil_resp_e rresp;
	} axil_rsp_t;

	// --------------------
	// register map
	localparam logic [axil_addr_w-1:0] reg_ctrl_addr = 12'h000;
	localparam logic [axil_addr_w-1:0] reg_status_addr = 12'h004;
	localparam logic [axil_addr_w-1:0] reg_len_addr = 12'h008;
	localparam logic [axil_addr_w-1:0] reg_invert_addr = 12'h00C;
	localparam logic [axil_addr_w-1:0] snap_base_addr = 12'h100;

endpackage

`default_nettype wire

/* design/xc_delay_lines.sv */
// --------------------
// input delay lines
// --------------------
`default_nettype none
`include "xc_config.svh"

module xc_delay_lines (
	input logic intclk,
	input logic rst_n,
	input logic [`XC_NUM_LINES-1:0] line_in,
	input logic [`XC_NUM_LINES-1:0] invert,
	output xc_types_pkg::taps_t taps
);

	logic [`XC_NUM_LINES-1:0] cond;

	// per-line polarity
	assign cond = line_in ^ invert;

	// runs every cycle, independent of the integration state
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			taps <= '0;
		end else begin
			taps.tap0 <= cond;
			taps.tap1 <= taps.tap0;
			taps.tap2 <= taps.tap1;
		end
	end

endmodule

`default_nettype wire

/* design/xc_lag_counters.sv */
// --------------------
// lag product counters
// --------------------
`default_nettype none
`include "xc_config.svh"

module xc_lag_counters (
	input logic intclk,
	input logic rst_n,
	input logic clear,
	input logic count_en,
	input xc_types_pkg::taps_t taps,
	output xc_types_pkg::count_vec_t counts
);

	localparam int nl = `XC_NUM_LINES;
	localparam int span = xc_types_pkg::cross_span;

	logic [nl-1:0] tap [0:`XC_MAX_LAG];
	logic [nl-1:0] pulse_hit;
	logic [xc_types_pkg::num_auto-1:0] auto_hit;
	logic [`XC_NUM_PAIRS*span-1:0] cross_hit;
	logic [`XC_NUM_COUNTS-1:0] hit;

	assign tap[0] = taps.tap0;
	assign tap[1] = taps.tap1;
	assign tap[2] = taps.tap2;

	// --------------------
	// one-bit products
	for (genvar a = 0; a < nl; a++) begin : g_line
		assign pulse_hit[a] = tap[0][a];

		for (genvar k = 1; k <= `XC_MAX_LAG; k++) begin : g_auto
			assign auto_hit[a*`XC_MAX_LAG + k - 1] = tap[0][a] & tap[k][a];
		end

		for (genvar b = a + 1; b < nl; b++) begin : g_pair
			// pairs run (0,1) (0,2) (0,3) (1,2) ...
			localparam int p = a * (2 * nl - a - 1) / 2 + (b - a - 1);

			for (genvar d = 0; d < span; d++) begin : g_lag
				localparam int lag = d - `XC_MAX_LAG;
				if (lag >= 0) begin : g_pos
					assign cross_hit[p*span + d] = tap[0][a] & tap[lag][b];
				end else begin : g_neg
					assign cross_hit[p*span + d] = tap[-lag][a] & tap[0][b];
				end
			end
		end
	end

	assign hit = {cross_hit, auto_hit, pulse_hit};

	// --------------------
	// saturating counters
	always_ff @(posedge intclk) begin
		if (!rst_n || clear) begin
			counts <= '0;
		end else if (count_en) begin
			for (int i = 0; i < `XC_NUM_COUNTS; i++) begin
				if (hit[i] && counts[i] != '1)
					counts[i] <= counts[i] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/xc_integration_ctrl.sv */
// --------------------
// integration control
// --------------------
`default_nettype none
`include "xc_config.svh"

module xc_integration_ctrl (
	input logic intclk,
	input logic rst_n,
	input xc_types_pkg::xc_ctrl_t ctrl,
	input xc_types_pkg::count_vec_t counts,
	input logic [$clog2(`XC_NUM_COUNTS)-1:0] snap_index,
	output logic clear,
	output logic count_en,
	output xc_types_pkg::xc_status_t status,
	output xc_types_pkg::count_t snap_word
);

	localparam int iw = $clog2(`XC_NUM_COUNTS);
	localparam logic [iw-1:0] last_walk = iw'(`XC_NUM_COUNTS);

	xc_types_pkg::xc_state_e state;
	logic [`XC_LEN_WIDTH-1:0] len_left;
	logic [iw-1:0] walk;
	xc_types_pkg::count_vec_t snapshot;
	xc_types_pkg::count_t walk_word;
	logic [7:0] ck_l;
	logic [7:0] ck_h;
	logic [7:0] sum_l0;
	logic [7:0] sum_h0;
	logic [7:0] sum_l1;
	logic [7:0] sum_h1;

	assign clear = (state == xc_types_pkg::st_clear);
	assign count_en = (state == xc_types_pkg::st_integrate);

	// walk 0 copies the counts, walk 1..42 folds in word walk-1
	assign walk_word = (walk != '0) ? snapshot[walk - 1'b1] : '0;

	// low byte first, then high byte
	always_comb begin
		sum_l0 = ck_l + walk_word[7:0];
		sum_h0 = ck_h + sum_l0;
		sum_l1 = sum_l0 + walk_word[15:8];
		sum_h1 = sum_h0 + sum_l1;
	end

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			state <= xc_types_pkg::st_idle;
			len_left <= '0;
			walk <= '0;
			snapshot <= '0;
			ck_l <= '0;
			ck_h <= '0;
		end else begin
			case (state)
				xc_types_pkg::st_idle, xc_types_pkg::st_done: begin
					if (ctrl.start) begin
						state <= xc_types_pkg::st_clear;
						len_left <= ctrl.int_len;
						walk <= '0;
						ck_l <= '0;
						ck_h <= '0;
					end
				end
				xc_types_pkg::st_clear: begin
					if (len_left == '0)
						state <= xc_types_pkg::st_checksum;
					else
						state <= xc_types_pkg::st_integrate;
				end
				xc_types_pkg::st_integrate: begin
					len_left <= len_left - 1'b1;
					if (len_left == 1)
						state <= xc_types_pkg::st_checksum;
				end
				xc_types_pkg::st_checksum: begin
					if (walk == '0) begin
						snapshot <= counts;
					end else begin
						ck_l <= sum_l1;
						ck_h <= sum_h1;
					end
					if (walk == last_walk)
						state <= xc_types_pkg::st_done;
					walk <= walk + 1'b1;
				end
				default: state <= xc_types_pkg::st_idle;
			endcase
		end
	end

	assign status.busy = clear || count_en || (state == xc_types_pkg::st_checksum);
	assign status.done = (state == xc_types_pkg::st_done);
	assign status.checksum = {ck_h, ck_l};

	assign snap_word = (snap_index < last_walk) ? snapshot[snap_index] : '0;

endmodule

`default_nettype wire

/* design/xc_axil_regs.sv */
// --------------------
// AXI4-Lite registers
// --------------------
`default_nettype none
`include "xc_config.svh"

module xc_axil_regs (
	input logic intclk,
	input logic rst_n,
	input xc_axil_pkg::axil_req_t axil_req,
	output xc_axil_pkg::axil_rsp_t axil_rsp,
	input xc_types_pkg::xc_status_t status,
	input xc_types_pkg::count_t snap_word,
	output xc_types_pkg::xc_ctrl_t ctrl,
	output logic [$clog2(`XC_NUM_COUNTS)-1:0] snap_index
);

	localparam int iw = $clog2(`XC_NUM_COUNTS);
	localparam logic [9:0] snap_first = xc_axil_pkg::snap_base_addr[11:2];

	logic aw_ready;
	logic ar_ready;
	logic b_valid;
	logic r_valid;
	xc_axil_pkg::axil_resp_e b_resp;
	xc_axil_pkg::axil_resp_e r_resp;
	logic [31:0] r_data;
	logic wr_fire;
	logic rd_fire;
	logic [11:0] wr_addr;
	logic [11:0] rd_addr;
	logic [9:0] rd_off;
	logic rd_snap;
	logic [31:0] rd_value;
	xc_axil_pkg::axil_resp_e rd_resp;

	assign wr_fire = aw_ready & axil_req.awvalid & axil_req.wvalid;
	assign rd_fire = ar_ready & axil_req.arvalid;

	// byte offsets below a word are ignored
	assign wr_addr = {axil_req.awaddr[11:2], 2'b00};
	assign rd_addr = {axil_req.araddr[11:2], 2'b00};

	// snapshot window, index goes straight to the control block
	assign rd_off = axil_req.araddr[11:2] - snap_first;
	assign rd_snap = (axil_req.araddr[11:2] >= snap_first) &&
		(rd_off < 10'(`XC_NUM_COUNTS));
	assign snap_index = rd_off[iw-1:0];

	always_comb begin
		rd_value = '0;
		rd_resp = xc_axil_pkg::OKAY;
		case (rd_addr)
			xc_axil_pkg::reg_ctrl_addr: rd_value = '0;
			xc_axil_pkg::reg_status_addr:
				rd_value = {status.checksum, 14'b0, status.done, status.busy};
			xc_axil_pkg::reg_len_addr: rd_value = 32'(ctrl.int_len);
			xc_axil_pkg::reg_invert_addr: rd_value = 32'(ctrl.invert);
			default: begin
				if (rd_snap)
					rd_value = 32'(snap_word);
				else
					rd_resp = xc_axil_pkg::SLVERR;
			end
		endcase
	end

	// --------------------
	// handshakes and control
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			aw_ready <= 1'b0;
			b_valid <= 1'b0;
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
			ctrl <= '0;
		end else begin
			ctrl.start <= 1'b0;
			aw_ready <= axil_req.awvalid && axil_req.wvalid && !aw_ready && !b_valid;
			ar_ready <= axil_req.arvalid && !ar_ready && !r_valid;

			if (wr_fire) begin
				b_valid <= 1'b1;
				case (wr_addr)
					xc_axil_pkg::reg_ctrl_addr:
						ctrl.start <= axil_req.wstrb[0] & axil_req.wdata[0];
					xc_axil_pkg::reg_len_addr: begin
						if (axil_req.wstrb[0])
							ctrl.int_len[7:0] <= axil_req.wdata[7:0];
						if (axil_req.wstrb[1])
							ctrl.int_len[15:8] <= axil_req.wdata[15:8];
					end
					xc_axil_pkg::reg_invert_addr: begin
						if (axil_req.wstrb[0])
							ctrl.invert <= axil_req.wdata[`XC_NUM_LINES-1:0];
					end
					default: ;
				endcase
			end else if (b_valid && axil_req.bready) begin
				b_valid <= 1'b0;
			end

			if (rd_fire)
				r_valid <= 1'b1;
			else if (r_valid && axil_req.rready)
				r_valid <= 1'b0;
		end
	end

	// response payloads
	always_ff @(posedge intclk) begin
		if (wr_fire) begin
			case (wr_addr)
				xc_axil_pkg::reg_ctrl_addr, xc_axil_pkg::reg_len_addr,
				xc_axil_pkg::reg_invert_addr: b_resp <= xc_axil_pkg::OKAY;
				default: b_resp <= xc_axil_pkg::SLVERR;
			endcase
		end
		if (rd_fire) begin
			r_data <= rd_value;
			r_resp <= rd_resp;
		end
	end

	assign axil_rsp.awready = aw_ready;
	assign axil_rsp.wready = aw_ready;
	assign axil_rsp.bvalid = b_valid;
	assign axil_rsp.bresp = b_resp;
	assign axil_rsp.arready = ar_ready;
	assign axil_rsp.rvalid = r_valid;
	assign axil_rsp.rdata = r_data;
	assign axil_rsp.rresp = r_resp;

endmodule

`default_nettype wire

/* design/xc_correlator_top.sv */
// --------------------
// correlator top
// --------------------
`default_nettype none
`include "xc_config.svh"

module xc_correlator_top (
	input logic intclk,
	input logic rst_n,
	input logic [`XC_NUM_LINES-1:0] line_in,
	input xc_axil_pkg::axil_req_t axil_req,
	output xc_axil_pkg::axil_rsp_t axil_rsp
);

	xc_types_pkg::xc_ctrl_t ctrl;
	xc_types_pkg::xc_status_t status;
	xc_types_pkg::taps_t taps;
	xc_types_pkg::count_vec_t counts;
	xc_types_pkg::count_t snap_word;
	logic [$clog2(`XC_NUM_COUNTS)-1:0] snap_index;
	logic clear;
	logic count_en;

	xc_delay_lines xc_delay_lines_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.line_in(line_in),
		.invert(ctrl.invert),
		.taps(taps)
	);

	xc_lag_counters xc_lag_counters_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.clear(clear),
		.count_en(count_en),
		.taps(taps),
		.counts(counts)
	);

	xc_integration_ctrl xc_integration_ctrl_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.counts(counts),
		.snap_index(snap_index),
		.clear(clear),
		.count_en(count_en),
		.status(status),
		.snap_word(snap_word)
	);

	xc_axil_regs xc_axil_regs_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.status(status),
		.snap_word(snap_word),
		.ctrl(ctrl),
		.snap_index(snap_index)
	);

endmodule

`default_nettype wire

/* testbench/tb_xc_correlator.sv */
// --------------------
// correlator testbench
// --------------------
`default_nettype none
`include "xc_config.svh"

module tb_xc_correlator;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int nc = `XC_NUM_COUNTS;
	localparam logic [11:0] unmapped_addr = 12'h200;

	logic intclk;
	logic rst_n;
	logic [`XC_NUM_LINES-1:0] line_in;
	xc_axil_pkg::axil_req_t req;
	xc_axil_pkg::axil_rsp_t axil_rsp;

	// stimulus control from the main process
	bit hold_line0;
	bit limits_set;
	int wd_cycles;
	logic [3:0] cur_inv;
	logic [15:0] cur_len;
	logic [15:0] len_a;
	logic [15:0] len_b;
	logic [15:0] len_d;
	logic [15:0] read_words [0:nc-1];

	// reference model state kept by the monitor
	logic [3:0] hist [0:2];
	logic [15:0] model_cnt [0:nc-1];
	bit model_run;
	int cyc;
	logic [15:0] run_len;
	logic [11:0] mon_raddr;

	xc_correlator_top xc_correlator_top_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.line_in(line_in),
		.axil_req(req),
		.axil_rsp(axil_rsp)
	);

	initial begin
		intclk = 1'b0;
		forever #20 intclk = ~intclk;
	end

	initial begin
		line_in = '0;
		forever begin
			@(posedge intclk);
			#2;
			line_in = 4'($urandom);
			if (hold_line0)
				line_in[0] = 1'b1;
		end
	end

	initial begin
		wait (limits_set);
		repeat (wd_cycles) @(posedge intclk);
		$display("watchdog: run did not finish within %0d cycles", wd_cycles);
		$display("Test FAILED");
		$fatal(1);
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// --------------------
	// reference model
	task automatic bump(input int i, input logic hit);
		if (hit && model_cnt[i] != 16'hFFFF)
			model_cnt[i] = model_cnt[i] + 16'd1;
	endtask

	task automatic count_model_sample();
		int p;
		p = 0;
		for (int a = 0; a < 4; a++)
			bump(a, hist[0][a]);
		for (int a = 0; a < 4; a++)
			for (int k = 1; k <= 2; k++)
				bump(4 + a * 2 + k - 1, hist[0][a] & hist[k][a]);
		for (int a = 0; a < 4; a++) begin
			for (int b = a + 1; b < 4; b++) begin
				for (int d = -2; d <= 2; d++) begin
					if (d >= 0)
						bump(12 + p * 5 + d + 2, hist[0][a] & hist[d][b]);
					else
						bump(12 + p * 5 + d + 2, hist[-d][a] & hist[0][b]);
				end
				p++;
			end
		end
	endtask

	// monitor samples the bus as it was just before each edge
	always @(posedge intclk) begin
		if (!rst_n) begin
			hist[0] = '0;
			hist[1] = '0;
			hist[2] = '0;
			model_run = 1'b0;
			cyc = 0;
		end else begin
			hist[2] = hist[1];
			hist[1] = hist[0];
			hist[0] = line_in ^ cur_inv;
			if (req.awvalid && axil_rsp.awready && req.wvalid && axil_rsp.wready &&
				req.awaddr[11:2] == 10'd0 && req.wstrb[0] && req.wdata[0] && !model_run) begin
				model_run = 1'b1;
				cyc = 0;
				run_len = cur_len;
				for (int i = 0; i < nc; i++)
					model_cnt[i] = '0;
			end else if (model_run) begin
				cyc++;
			end
			if (model_run && cyc >= 2 && cyc <= int'(run_len) + 1)
				count_model_sample();
			if (req.arvalid && axil_rsp.arready)
				mon_raddr = req.araddr;
			if (axil_rsp.rvalid && req.rready && mon_raddr == xc_axil_pkg::reg_status_addr &&
				model_run) begin
				check_value("status busy or done", 32'(axil_rsp.rdata[1:0] != 2'b00), 32'd1);
				if (axil_rsp.rdata[1])
					model_run = 1'b0;
			end
		end
	end

	function automatic logic [15:0] checksum_of_reads();
		logic [7:0] lo;
		logic [7:0] hi;
		lo = 8'd0;
		hi = 8'd0;
		for (int i = 0; i < nc; i++) begin
			lo = lo + read_words[i][7:0];
			hi = hi + lo;
			lo = lo + read_words[i][15:8];
			hi = hi + lo;
		end
		return {hi, lo};
	endfunction

	// --------------------
	// AXI4-Lite master tasks enter and leave 2 ns after an edge
	task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
		output xc_axil_pkg::axil_resp_e resp);
		int dly;
		dly = $urandom_range(2, 0);
		req.awvalid = 1'b1;
		req.awaddr = addr;
		req.wvalid = 1'b1;
		req.wdata = data;
		req.wstrb = 4'hF;
		req.bready = 1'b0;
		while (!(axil_rsp.awready && axil_rsp.wready)) begin
			@(posedge intclk);
			#2;
		end
		@(posedge intclk);
		#2;
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		while (!axil_rsp.bvalid) begin
			@(posedge intclk);
			#2;
		end
		repeat (dly) begin
			@(posedge intclk);
			#2;
		end
		resp = axil_rsp.bresp;
		req.bready = 1'b1;
		@(posedge intclk);
		#2;
		req.bready = 1'b0;
	endtask

	task automatic read_reg(input logic [11:0] addr, output logic [31:0] data,
		output xc_axil_pkg::axil_resp_e resp);
		int dly;
		dly = $urandom_range(2, 0);
		req.arvalid = 1'b1;
		req.araddr = addr;
		req.rready = 1'b0;
		while (!axil_rsp.arready) begin
			@(posedge intclk);
			#2;
		end
		@(posedge intclk);
		#2;
		req.arvalid = 1'b0;
		while (!axil_rsp.rvalid) begin
			@(posedge intclk);
			#2;
		end
		repeat (dly) begin
			@(posedge intclk);
			#2;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		req.rready = 1'b1;
		@(posedge intclk);
		#2;
		req.rready = 1'b0;
	endtask

	// --------------------
	// one integration run checked against the model
	task automatic run_and_check(input logic [3:0] inv, input logic [15:0] len, input bit restart);
		xc_axil_pkg::axil_resp_e resp;
		logic [31:0] data;
		cur_inv = inv;
		write_reg(xc_axil_pkg::reg_invert_addr, 32'(inv), resp);
		check_value("bresp invert", 32'(resp), 32'(xc_axil_pkg::OKAY));
		cur_len = len;
		write_reg(xc_axil_pkg::reg_len_addr, 32'(len), resp);
		check_value("bresp length", 32'(resp), 32'(xc_axil_pkg::OKAY));
		write_reg(xc_axil_pkg::reg_ctrl_addr, 32'd1, resp);
		check_value("bresp ctrl", 32'(resp), 32'(xc_axil_pkg::OKAY));
		// second start lands while the first run is integrating
		if (restart) begin
			write_reg(xc_axil_pkg::reg_ctrl_addr, 32'd1, resp);
			check_value("bresp ctrl restart", 32'(resp), 32'(xc_axil_pkg::OKAY));
		end
		do begin
			read_reg(xc_axil_pkg::reg_status_addr, data, resp);
			check_value("rresp status", 32'(resp), 32'(xc_axil_pkg::OKAY));
		end while (!data[1]);
		for (int i = 0; i < nc; i++) begin
			read_reg(xc_axil_pkg::snap_base_addr + 12'(4 * i), data, resp);
			check_value($sformatf("rresp snap[%0d]", i), 32'(resp), 32'(xc_axil_pkg::OKAY));
			check_value($sformatf("snap[%0d]", i), data, {16'h0, model_cnt[i]});
			read_words[i] = data[15:0];
		end
		read_reg(xc_axil_pkg::reg_status_addr, data, resp);
		check_value("status checksum", 32'(data[31:16]), 32'(checksum_of_reads()));
	endtask

	initial begin
		xc_axil_pkg::axil_resp_e resp;
		logic [31:0] data;
		void'($urandom(84));
		req = '0;
		rst_n = 1'b0;
		hold_line0 = 1'b0;
		cur_inv = '0;
		cur_len = '0;
		len_a = 16'($urandom_range(300, 50));
		len_b = 16'($urandom_range(300, 50));
		len_d = 16'($urandom_range(300, 50));
		wd_cycles = int'(len_a) + int'(len_b) + int'(len_d) + 65535 + 2000;
		limits_set = 1'b1;
		repeat (4) @(posedge intclk);
		#2;
		rst_n = 1'b1;

		// reset values
		check_value("awready wready bvalid arready rvalid after reset",
			32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid, axil_rsp.arready,
			axil_rsp.rvalid}), 32'h0);
		read_reg(xc_axil_pkg::reg_status_addr, data, resp);
		check_value("status after reset", data, 32'h0);
		check_value("rresp status", 32'(resp), 32'(xc_axil_pkg::OKAY));
		read_reg(xc_axil_pkg::reg_len_addr, data, resp);
		check_value("length after reset", data, 32'h0);
		check_value("rresp length", 32'(resp), 32'(xc_axil_pkg::OKAY));
		read_reg(xc_axil_pkg::reg_invert_addr, data, resp);
		check_value("invert after reset", data, 32'h0);
		check_value("rresp invert", 32'(resp), 32'(xc_axil_pkg::OKAY));
		for (int i = 0; i < nc; i++) begin
			read_reg(xc_axil_pkg::snap_base_addr + 12'(4 * i), data, resp);
			check_value($sformatf("snap[%0d] after reset", i), data, 32'h0);
			check_value("rresp snap", 32'(resp), 32'(xc_axil_pkg::OKAY));
		end

		run_and_check(4'h0, len_a, 1'b0);
		run_and_check(4'($urandom), len_b, 1'b0);

		// length register keeps 16 bits
		write_reg(xc_axil_pkg::reg_len_addr, 32'd70000, resp);
		read_reg(xc_axil_pkg::reg_len_addr, data, resp);
		check_value("length truncated", data, 32'd70000 & 32'hFFFF);

		hold_line0 = 1'b1;
		run_and_check(4'h0, 16'hFFFF, 1'b0);
		check_value("pulse line 0 saturated", 32'(read_words[0]), 32'hFFFF);
		check_value("auto lag 1 line 0 saturated", 32'(read_words[4]), 32'hFFFF);
		hold_line0 = 1'b0;

		// error responses
		write_reg(xc_axil_pkg::reg_status_addr, 32'h3, resp);
		check_value("bresp status write", 32'(resp), 32'(xc_axil_pkg::SLVERR));
		read_reg(unmapped_addr, data, resp);
		check_value("rresp unmapped", 32'(resp), 32'(xc_axil_pkg::SLVERR));
		check_value("rdata unmapped", data, 32'h0);

		run_and_check(4'($urandom), len_d, 1'b1);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* xc_correlator_top.f */
+incdir+design
design/xc_types_pkg.sv
design/xc_axil_pkg.sv
design/xc_delay_lines.sv
design/xc_lag_counters.sv
design/xc_integration_ctrl.sv
design/xc_axil_regs.sv
design/xc_correlator_top.sv
testbench/tb_xc_correlator.sv

/* run_sim.sh */
#!/bin/sh
# build the correlator testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_xc_correlator \
	-f xc_correlator_top.f -o tb_xc_correlator \
	&& ./obj_dir/tb_xc_correlator | tee /dev/stderr | grep -qx "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
